//--- Makefile
SIM = obj_dir/mem_proxy_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module mem_proxy_tb \
		-f project.f -o mem_proxy_sim

run: compile
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Checks failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- axi3_mem.sv
`timescale 1ns/1ns

module axi3_mem #(
    parameter int ADDR_WID = 8,
    parameter int DEPTH    = 200
) (
    input  logic     clk,
    input  logic     rst_n,
    axi3_intf.slave  axi
);

    localparam int DW = mem_proxy_pkg::DATA_WID;

    logic [DW-1:0]       mem_q [DEPTH];

    // Write collection
    logic                aw_got;
    logic                w_got;
    logic [ADDR_WID-1:0] wr_idx;
    logic                wr_size_ok;
    logic [DW-1:0]       wr_data;
    logic                wr_last;
    logic                wr_ok;
    logic                wr_en;

    // Read decode
    logic [ADDR_WID-1:0] rd_idx;
    logic                rd_ok;

    // No new address while a response is outstanding
    assign axi.awready = !aw_got && !axi.bvalid;
    assign axi.wready  = !w_got && !axi.bvalid;
    assign axi.arready = !axi.rvalid;

    assign wr_ok  = (wr_idx < DEPTH) && wr_size_ok && wr_last;
    assign wr_en  = aw_got && w_got && wr_ok;

    assign rd_idx = axi.araddr[ADDR_WID+1:2];
    assign rd_ok  = (rd_idx < DEPTH) && (axi.arsize == mem_proxy_pkg::SIZE_4BYTES);

    // Word array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_idx] <= wr_data;
        end
    end

    //==========================================================
    // Channel control
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            wr_idx     <= '0;
            wr_size_ok <= 1'b0;
            wr_data    <= '0;
            wr_last    <= 1'b0;
            axi.bvalid <= 1'b0;
            axi.bresp  <= mem_proxy_pkg::RESP_OKAY;
            axi.rvalid <= 1'b0;
            axi.rdata  <= '0;
            axi.rresp  <= mem_proxy_pkg::RESP_OKAY;
            axi.rlast  <= 1'b0;
        end else begin
            // AW and W in either order
            if (axi.awvalid && axi.awready) begin
                aw_got     <= 1'b1;
                wr_idx     <= axi.awaddr[ADDR_WID+1:2];
                wr_size_ok <= (axi.awsize == mem_proxy_pkg::SIZE_4BYTES);
            end
            if (axi.wvalid && axi.wready) begin
                w_got   <= 1'b1;
                wr_data <= axi.wdata;
                wr_last <= axi.wlast;
            end

            // Both halves in, write and respond
            if (aw_got && w_got) begin
                aw_got     <= 1'b0;
                w_got      <= 1'b0;
                axi.bvalid <= 1'b1;
                axi.bresp  <= wr_ok ? mem_proxy_pkg::RESP_OKAY : mem_proxy_pkg::RESP_SLVERR;
            end else if (axi.bvalid && axi.bready) begin
                axi.bvalid <= 1'b0;
            end

            // Read, zero data outside the array
            if (axi.arvalid && axi.arready) begin
                axi.rvalid <= 1'b1;
                axi.rlast  <= 1'b1;
                axi.rdata  <= rd_ok ? mem_q[rd_idx] : '0;
                axi.rresp  <= rd_ok ? mem_proxy_pkg::RESP_OKAY : mem_proxy_pkg::RESP_SLVERR;
            end else if (axi.rvalid && axi.rready) begin
                axi.rvalid <= 1'b0;
                axi.rlast  <= 1'b0;
            end
        end
    end

endmodule : axi3_mem

//--- mem_axi3_proxy.sv
`timescale 1ns/1ns

module mem_axi3_proxy #(
    parameter int ADDR_WID = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    mem_req_intf.mem  mem,
    axi3_intf.master  axi
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP,
        ST_ACK
    } state_t;

    state_t              state;
    logic                wr_q;
    logic [ADDR_WID+1:0] byte_addr;
    logic                aw_done;
    logic                w_done;
    logic                ar_done;

    // Request fields stay stable until ack, drive AXI directly
    assign byte_addr  = {mem.addr, 2'b00};
    assign axi.awaddr = byte_addr;
    assign axi.araddr = byte_addr;
    assign axi.wdata  = mem.wdata;
    assign axi.awsize = mem_proxy_pkg::SIZE_4BYTES;
    assign axi.arsize = mem_proxy_pkg::SIZE_4BYTES;
    // Every beat is the last one
    assign axi.wlast  = 1'b1;

    // Ready only for the response we are waiting on
    assign axi.bready = (state == ST_RESP) && wr_q;
    assign axi.rready = (state == ST_RESP) && !wr_q;

    // Channel idle or transferring this edge
    assign aw_done = !axi.awvalid || axi.awready;
    assign w_done  = !axi.wvalid  || axi.wready;
    assign ar_done = !axi.arvalid || axi.arready;

    //==========================================================
    // Request FSM
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            wr_q        <= 1'b0;
            axi.awvalid <= 1'b0;
            axi.wvalid  <= 1'b0;
            axi.arvalid <= 1'b0;
            mem.ack     <= 1'b0;
            mem.rdata   <= '0;
            mem.err     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (mem.req) begin
                        wr_q        <= mem.wr;
                        // AW and W together on a write
                        axi.awvalid <= mem.wr;
                        axi.wvalid  <= mem.wr;
                        axi.arvalid <= !mem.wr;
                        state       <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (axi.awvalid && axi.awready) begin
                        axi.awvalid <= 1'b0;
                    end
                    if (axi.wvalid && axi.wready) begin
                        axi.wvalid <= 1'b0;
                    end
                    if (axi.arvalid && axi.arready) begin
                        axi.arvalid <= 1'b0;
                    end
                    if (aw_done && w_done && ar_done) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (axi.bvalid && axi.bready) begin
                        mem.err <= (axi.bresp != mem_proxy_pkg::RESP_OKAY);
                        mem.ack <= 1'b1;
                        state   <= ST_ACK;
                    end
                    if (axi.rvalid && axi.rready) begin
                        mem.rdata <= axi.rdata;
                        // Missing rlast counts as an error too
                        mem.err   <= (axi.rresp != mem_proxy_pkg::RESP_OKAY) || !axi.rlast;
                        mem.ack   <= 1'b1;
                        state     <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // Hold ack until requester lets go
                    if (!mem.req) begin
                        mem.ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule : mem_axi3_proxy

//--- mem_proxy_assertions.sv
`timescale 1ns/1ns

module mem_proxy_assertions (
    input logic clk,
    input logic rst_n,
    input logic awvalid,
    input logic awready,
    input logic arvalid,
    input logic arready,
    input logic mem_req,
    input logic mem_ack
);

    // Address valids held until the slave takes them
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // One direction per request
    aw_ar_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(awvalid && arvalid))
        else $error("awvalid and arvalid high together");

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_ack) |-> mem_req)
        else $error("mem ack rose without mem req");

endmodule : mem_proxy_assertions

bind mem_axi3_proxy mem_proxy_assertions u_assertions (
    .clk     ( clk ),
    .rst_n   ( rst_n ),
    .awvalid ( axi.awvalid ),
    .awready ( axi.awready ),
    .arvalid ( axi.arvalid ),
    .arready ( axi.arready ),
    .mem_req ( mem.req ),
    .mem_ack ( mem.ack )
);

//--- mem_proxy_intf.sv
`timescale 1ns/1ns

// Four-phase memory request between register block and AXI3 adapter
interface mem_req_intf #(
    parameter int ADDR_WID = 8
);
    logic                                req;
    logic                                ack;
    logic                                wr;
    logic [ADDR_WID-1:0]                 addr;
    logic [mem_proxy_pkg::DATA_WID-1:0]  wdata;
    // Valid while ack is high
    logic [mem_proxy_pkg::DATA_WID-1:0]  rdata;
    logic                                err;

    modport ctrl (
        output req, wr, addr, wdata,
        input  ack, rdata, err
    );

    modport mem (
        input  req, wr, addr, wdata,
        output ack, rdata, err
    );
endinterface : mem_req_intf

// Single-beat AXI3, no IDs and no strobes
interface axi3_intf #(
    parameter int ADDR_WID = 8
);
    // Byte addresses, two bits wider than the word address
    logic                                awvalid;
    logic                                awready;
    logic [ADDR_WID+1:0]                 awaddr;
    mem_proxy_pkg::axsize_t              awsize;

    logic                                wvalid;
    logic                                wready;
    logic [mem_proxy_pkg::DATA_WID-1:0]  wdata;
    logic                                wlast;

    logic                                bvalid;
    logic                                bready;
    mem_proxy_pkg::resp_t                bresp;

    logic                                arvalid;
    logic                                arready;
    logic [ADDR_WID+1:0]                 araddr;
    mem_proxy_pkg::axsize_t              arsize;

    logic                                rvalid;
    logic                                rready;
    logic [mem_proxy_pkg::DATA_WID-1:0]  rdata;
    mem_proxy_pkg::resp_t                rresp;
    logic                                rlast;

    modport master (
        output awvalid, awaddr, awsize, wvalid, wdata, wlast, bready,
        output arvalid, araddr, arsize, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp, rlast
    );

    modport slave (
        input  awvalid, awaddr, awsize, wvalid, wdata, wlast, bready,
        input  arvalid, araddr, arsize, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp, rlast
    );
endinterface : axi3_intf

//--- mem_proxy_pkg.sv
package mem_proxy_pkg;

    //==========================================================
    // Data path
    //==========================================================
    // One word per beat on every bus
    localparam int DATA_WID = 32;

    //==========================================================
    // Codes
    //==========================================================
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2
    } cmd_t;

    typedef enum logic [7:0] {
        MEM_TYPE_SRAM = 8'd0,
        MEM_TYPE_DDR  = 8'd1,
        MEM_TYPE_HBM  = 8'd2
    } mem_type_t;

    typedef enum logic [1:0] {
        ACCESS_NONE       = 2'd0,
        ACCESS_READ_ONLY  = 2'd1,
        ACCESS_WRITE_ONLY = 2'd2,
        ACCESS_READ_WRITE = 2'd3
    } access_t;

    // AXI3 AxSIZE, bytes per beat as a power of two
    typedef enum logic [2:0] {
        SIZE_1BYTE   = 3'd0,
        SIZE_2BYTES  = 3'd1,
        SIZE_4BYTES  = 3'd2,
        SIZE_8BYTES  = 3'd3,
        SIZE_16BYTES = 3'd4,
        SIZE_32BYTES = 3'd5
    } axsize_t;

    // AXI3 BRESP / RRESP
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_EXOKAY = 2'd1,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_t;

    //==========================================================
    // Register map, word addresses
    //==========================================================
    localparam logic [3:0] REG_CMD       = 4'd0;  // Status on read
    localparam logic [3:0] REG_ADDR      = 4'd1;
    localparam logic [3:0] REG_WDATA     = 4'd2;
    localparam logic [3:0] REG_RDATA     = 4'd3;
    localparam logic [3:0] REG_TYPE      = 4'd4;
    localparam logic [3:0] REG_ACCESS    = 4'd5;
    localparam logic [3:0] REG_ALIGN     = 4'd6;
    localparam logic [3:0] REG_SIZE      = 4'd7;
    localparam logic [3:0] REG_MIN_BURST = 4'd8;
    localparam logic [3:0] REG_MAX_BURST = 4'd9;

endpackage : mem_proxy_pkg

//--- mem_proxy_regs.sv
`timescale 1ns/1ns

module mem_proxy_regs #(
    parameter int ADDR_WID = 8,
    parameter int DEPTH    = 200
) (
    input  logic                               clk,
    input  logic                               rst_n,
    // Host register bus
    input  logic                               reg_req,
    input  logic                               reg_wr,
    input  logic [3:0]                         reg_addr,
    input  logic [mem_proxy_pkg::DATA_WID-1:0] reg_wdata,
    output logic                               reg_ack,
    output logic [mem_proxy_pkg::DATA_WID-1:0] reg_rdata,
    // Memory request side
    mem_req_intf.ctrl                          mem
);

    localparam int DW             = mem_proxy_pkg::DATA_WID;
    localparam int BYTES_PER_WORD = DW / 8;

    logic [ADDR_WID-1:0] addr_q;
    logic [DW-1:0]       wdata_q;
    logic [DW-1:0]       rdata_q;
    logic                cmd_wr_q;
    logic                launch_q;
    logic                busy_q;
    logic                error_q;
    logic                host_strobe;
    logic [DW-1:0]       rd_word;

    // First cycle of a host request, ack not yet raised
    assign host_strobe = reg_req && !reg_ack;

    //==========================================================
    // Register read decode
    //==========================================================
    always_comb begin
        rd_word = '0;
        case (reg_addr)
            mem_proxy_pkg::REG_CMD: begin
                // Busy covers a launch still pending
                rd_word[0] = busy_q || launch_q;
                rd_word[1] = error_q;
            end
            mem_proxy_pkg::REG_ADDR:      rd_word[ADDR_WID-1:0] = addr_q;
            mem_proxy_pkg::REG_WDATA:     rd_word = wdata_q;
            mem_proxy_pkg::REG_RDATA:     rd_word = rdata_q;
            mem_proxy_pkg::REG_TYPE:      rd_word = DW'(mem_proxy_pkg::MEM_TYPE_SRAM);
            mem_proxy_pkg::REG_ACCESS:    rd_word = DW'(mem_proxy_pkg::ACCESS_READ_WRITE);
            mem_proxy_pkg::REG_ALIGN:     rd_word = DW'(BYTES_PER_WORD);
            mem_proxy_pkg::REG_SIZE:      rd_word = DW'(BYTES_PER_WORD * DEPTH);
            // Single-beat bursts only
            mem_proxy_pkg::REG_MIN_BURST: rd_word = DW'(BYTES_PER_WORD);
            mem_proxy_pkg::REG_MAX_BURST: rd_word = DW'(BYTES_PER_WORD);
            default:                      rd_word = '0;
        endcase
    end

    //==========================================================
    // Host handshake, command launch and completion
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_ack   <= 1'b0;
            reg_rdata <= '0;
            addr_q    <= '0;
            wdata_q   <= '0;
            rdata_q   <= '0;
            cmd_wr_q  <= 1'b0;
            launch_q  <= 1'b0;
            busy_q    <= 1'b0;
            error_q   <= 1'b0;
            mem.req   <= 1'b0;
            mem.wr    <= 1'b0;
            mem.addr  <= '0;
            mem.wdata <= '0;
        end else begin
            // Ack follows req by one cycle both ways
            reg_ack <= reg_req;

            if (host_strobe) begin
                if (reg_wr) begin
                    case (reg_addr)
                        mem_proxy_pkg::REG_ADDR:  addr_q  <= reg_wdata[ADDR_WID-1:0];
                        mem_proxy_pkg::REG_WDATA: wdata_q <= reg_wdata;
                        mem_proxy_pkg::REG_CMD: begin
                            // Commands while busy are dropped
                            if (!busy_q && !launch_q) begin
                                case (mem_proxy_pkg::cmd_t'(reg_wdata[1:0]))
                                    mem_proxy_pkg::CMD_NOP: error_q <= 1'b0;
                                    mem_proxy_pkg::CMD_WRITE: begin
                                        launch_q <= 1'b1;
                                        cmd_wr_q <= 1'b1;
                                    end
                                    mem_proxy_pkg::CMD_READ: begin
                                        launch_q <= 1'b1;
                                        cmd_wr_q <= 1'b0;
                                    end
                                    default: ;
                                endcase
                            end
                        end
                        // Info and read data registers are read only
                        default: ;
                    endcase
                end else begin
                    reg_rdata <= rd_word;
                end
            end

            // Raise mem req once the previous ack has dropped
            if (launch_q && !mem.ack) begin
                launch_q  <= 1'b0;
                busy_q    <= 1'b1;
                mem.req   <= 1'b1;
                mem.wr    <= cmd_wr_q;
                mem.addr  <= addr_q;
                mem.wdata <= wdata_q;
            end

            // Completion
            if (mem.req && mem.ack) begin
                mem.req <= 1'b0;
                busy_q  <= 1'b0;
                error_q <= mem.err;
                if (!mem.wr) begin
                    rdata_q <= mem.rdata;
                end
            end
        end
    end

endmodule : mem_proxy_regs

//--- mem_proxy_tb.sv
`timescale 1ns/1ns

module mem_proxy_tb;

    localparam int ADDR_WID    = 8;
    localparam int DEPTH       = 200;
    localparam int DW          = mem_proxy_pkg::DATA_WID;
    localparam int CLK_PERIOD  = 40;
    localparam int ACK_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 30;

    logic          clk;
    logic          rst_n;
    logic          reg_req;
    logic          reg_wr;
    logic [3:0]    reg_addr;
    logic [DW-1:0] reg_wdata;
    logic          reg_ack;
    logic [DW-1:0] reg_rdata;

    integer        seed;
    // Expected memory contents
    logic [DW-1:0] shadow [DEPTH];

    // Command table with one entry per index
    string               t_name [$];
    logic [1:0]          t_cmd [$];
    logic [ADDR_WID-1:0] t_addr [$];
    logic [DW-1:0]       t_data [$];
    logic                t_rnd [$];
    logic [DW-1:0]       t_exp_rdata [$];
    logic                t_use_shadow [$];
    logic                t_exp_err [$];

    mem_proxy_top #(
        .ADDR_WID ( ADDR_WID ),
        .DEPTH    ( DEPTH )
    ) dut0 (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .reg_req   ( reg_req ),
        .reg_wr    ( reg_wr ),
        .reg_addr  ( reg_addr ),
        .reg_wdata ( reg_wdata ),
        .reg_ack   ( reg_ack ),
        .reg_rdata ( reg_rdata )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //============================================================
    // Reporting
    //============================================================
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    //============================================================
    // Four-phase host register bus
    //============================================================
    // Sampled on falling edges since ack moves on rising ones
    task automatic wait_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (reg_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                $display("Timeout: %s", what);
                abort_run();
            end
        end
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [DW-1:0] data);
        reg_addr  = addr;
        reg_wr    = 1'b1;
        reg_wdata = data;
        reg_req   = 1'b1;
        wait_ack(1'b1, "reg_ack never rose on a register write");
        reg_req = 1'b0;
        wait_ack(1'b0, "reg_ack never fell after a register write");
    endtask

    task automatic reg_read(input logic [3:0] addr, output logic [DW-1:0] data);
        reg_addr = addr;
        reg_wr   = 1'b0;
        reg_req  = 1'b1;
        wait_ack(1'b1, "reg_ack never rose on a register read");
        // Read data valid together with ack
        data    = reg_rdata;
        reg_req = 1'b0;
        wait_ack(1'b0, "reg_ack never fell after a register read");
    endtask

    // Status reads until busy is gone
    task automatic poll_idle(output logic [DW-1:0] status);
        int reads;
        reads = 0;
        reg_read(mem_proxy_pkg::REG_CMD, status);
        while (status[0]) begin
            reads++;
            if (reads > POLL_LIMIT) begin
                $display("Timeout: busy bit never cleared in the status register");
                abort_run();
            end
            reg_read(mem_proxy_pkg::REG_CMD, status);
        end
    endtask

    //============================================================
    // Command table
    //============================================================
    task automatic add_row(input string name, input logic [1:0] cmd,
                           input logic [ADDR_WID-1:0] addr, input logic [DW-1:0] data,
                           input logic rnd, input logic [DW-1:0] exp_rdata,
                           input logic use_shadow, input logic exp_err);
        t_name.push_back(name);
        t_cmd.push_back(cmd);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_rnd.push_back(rnd);
        t_exp_rdata.push_back(exp_rdata);
        t_use_shadow.push_back(use_shadow);
        t_exp_err.push_back(exp_err);
    endtask

    task automatic load_table();
        add_row("nop_first",    mem_proxy_pkg::CMD_NOP,   8'd0,   32'h0,         0, 0, 0, 0);
        // Several writes before any read back
        add_row("wr_a0",        mem_proxy_pkg::CMD_WRITE, 8'd0,   32'h1234_5678, 0, 0, 0, 0);
        add_row("wr_a1",        mem_proxy_pkg::CMD_WRITE, 8'd1,   32'h0,         1, 0, 0, 0);
        add_row("wr_a57",       mem_proxy_pkg::CMD_WRITE, 8'd57,  32'h0,         1, 0, 0, 0);
        add_row("wr_a199",      mem_proxy_pkg::CMD_WRITE, 8'd199, 32'hdead_beef, 0, 0, 0, 0);
        add_row("rd_a0",        mem_proxy_pkg::CMD_READ,  8'd0,   32'h0,         0, 0, 1, 0);
        add_row("rd_a1",        mem_proxy_pkg::CMD_READ,  8'd1,   32'h0,         0, 0, 1, 0);
        add_row("rd_a57",       mem_proxy_pkg::CMD_READ,  8'd57,  32'h0,         0, 0, 1, 0);
        add_row("rd_a199",      mem_proxy_pkg::CMD_READ,  8'd199, 32'h0,         0, 0, 1, 0);
        // First word past the array
        add_row("wr_oob",       mem_proxy_pkg::CMD_WRITE, 8'd200, 32'hffff_ffff, 0, 0, 0, 1);
        add_row("nop_clear",    mem_proxy_pkg::CMD_NOP,   8'd0,   32'h0,         0, 0, 0, 0);
        add_row("rd_oob",       mem_proxy_pkg::CMD_READ,  8'd255, 32'h0,         0, 0, 0, 1);
        add_row("rd_a199_post", mem_proxy_pkg::CMD_READ,  8'd199, 32'h0,         0, 0, 1, 0);
        add_row("rd_a0_post",   mem_proxy_pkg::CMD_READ,  8'd0,   32'h0,         0, 0, 1, 0);
        add_row("wr_a0_again",  mem_proxy_pkg::CMD_WRITE, 8'd0,   32'h0,         1, 0, 0, 0);
        add_row("rd_a0_again",  mem_proxy_pkg::CMD_READ,  8'd0,   32'h0,         0, 0, 1, 0);
    endtask

    task automatic run_row(input int i);
        logic [DW-1:0] data;
        logic [DW-1:0] status;
        logic [DW-1:0] rd;
        logic [DW-1:0] exp_rd;
        data = t_rnd[i] ? DW'($random(seed)) : t_data[i];
        if (t_cmd[i] != mem_proxy_pkg::CMD_NOP) begin
            reg_write(mem_proxy_pkg::REG_ADDR, DW'(t_addr[i]));
        end
        if (t_cmd[i] == mem_proxy_pkg::CMD_WRITE) begin
            reg_write(mem_proxy_pkg::REG_WDATA, data);
        end
        reg_write(mem_proxy_pkg::REG_CMD, DW'(t_cmd[i]));
        poll_idle(status);
        check_value({t_name[i], " error bit"}, DW'(t_exp_err[i]), DW'(status[1]));
        // Only in-range writes reach the array
        if (t_cmd[i] == mem_proxy_pkg::CMD_WRITE && int'(t_addr[i]) < DEPTH) begin
            shadow[t_addr[i]] = data;
        end
        if (t_cmd[i] == mem_proxy_pkg::CMD_READ) begin
            reg_read(mem_proxy_pkg::REG_RDATA, rd);
            exp_rd = t_use_shadow[i] ? shadow[t_addr[i]] : t_exp_rdata[i];
            check_value({t_name[i], " read data"}, exp_rd, rd);
        end
    endtask

    //============================================================
    // Main sequence
    //============================================================
    initial begin
        logic [DW-1:0] rd;
        seed        = 15;
        rst_n       = 1'b0;
        reg_req     = 1'b0;
        reg_wr      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // State right after reset
        check_value("reset reg_ack", '0, DW'(reg_ack));
        reg_read(mem_proxy_pkg::REG_CMD, rd);
        check_value("reset status", '0, rd);
        reg_read(mem_proxy_pkg::REG_RDATA, rd);
        check_value("reset rdata", '0, rd);

        // Info registers
        reg_read(mem_proxy_pkg::REG_TYPE, rd);
        check_value("info type", DW'(mem_proxy_pkg::MEM_TYPE_SRAM), rd);
        reg_read(mem_proxy_pkg::REG_ACCESS, rd);
        check_value("info access", DW'(mem_proxy_pkg::ACCESS_READ_WRITE), rd);
        reg_read(mem_proxy_pkg::REG_ALIGN, rd);
        check_value("info align", 32'd4, rd);
        reg_read(mem_proxy_pkg::REG_SIZE, rd);
        check_value("info size", DW'(4 * DEPTH), rd);
        reg_read(mem_proxy_pkg::REG_MIN_BURST, rd);
        check_value("info min burst", 32'd4, rd);
        reg_read(mem_proxy_pkg::REG_MAX_BURST, rd);
        check_value("info max burst", 32'd4, rd);

        load_table();
        for (int i = 0; i < t_name.size(); i++) begin
            run_row(i);
        end

        // Any failed check has already stopped the run
        $display("All checks passed");
        $finish;
    end

endmodule : mem_proxy_tb

//--- mem_proxy_top.sv
`timescale 1ns/1ns

module mem_proxy_top #(
    parameter int ADDR_WID = 8,
    parameter int DEPTH    = 200
) (
    input  logic                               clk,
    input  logic                               rst_n,
    // Host register bus
    input  logic                               reg_req,
    input  logic                               reg_wr,
    input  logic [3:0]                         reg_addr,
    input  logic [mem_proxy_pkg::DATA_WID-1:0] reg_wdata,
    output logic                               reg_ack,
    output logic [mem_proxy_pkg::DATA_WID-1:0] reg_rdata
);

    mem_req_intf #(.ADDR_WID(ADDR_WID)) mem_if ();
    axi3_intf    #(.ADDR_WID(ADDR_WID)) axi3_if ();

    // Register front end
    mem_proxy_regs #(
        .ADDR_WID ( ADDR_WID ),
        .DEPTH    ( DEPTH )
    ) i_regs (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .reg_req   ( reg_req ),
        .reg_wr    ( reg_wr ),
        .reg_addr  ( reg_addr ),
        .reg_wdata ( reg_wdata ),
        .reg_ack   ( reg_ack ),
        .reg_rdata ( reg_rdata ),
        .mem       ( mem_if.ctrl )
    );

    // Request to AXI3 beat
    mem_axi3_proxy #(
        .ADDR_WID ( ADDR_WID )
    ) i_axi3_proxy (
        .clk   ( clk ),
        .rst_n ( rst_n ),
        .mem   ( mem_if.mem ),
        .axi   ( axi3_if.master )
    );

    axi3_mem #(
        .ADDR_WID ( ADDR_WID ),
        .DEPTH    ( DEPTH )
    ) i_axi3_mem (
        .clk   ( clk ),
        .rst_n ( rst_n ),
        .axi   ( axi3_if.slave )
    );

endmodule : mem_proxy_top

//--- project.f
mem_proxy_pkg.sv
mem_proxy_intf.sv
mem_proxy_regs.sv
mem_axi3_proxy.sv
axi3_mem.sv
mem_proxy_top.sv
mem_proxy_assertions.sv
mem_proxy_tb.sv
